// File: l2_array.sv
module l2_array #(
  parameter int width = 1
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [l2_types_pkg::index_w-1:0]  index,
  input  logic                              write,
  input  logic [width-1:0]                  datain,
  output logic [width-1:0]                  dataout
);
  import l2_types_pkg::*;

  logic [width-1:0] entry [2**index_w];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2**index_w; i++)
      begin
        entry[i] <= '0;
      end
    end
    else if (write)
    begin
      entry[index] <= datain;
    end
  end

  assign dataout = entry[index];                    // Read is combinational

endmodule

// File: l2_cache.f
l2_types_pkg.sv
l2_array.sv
l2_plru.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache.sv
l2_mem_model.sv
l2_cache_tb.sv

// File: l2_cache.sv
module l2_cache (
  input  logic                                        clk,
  input  logic                                        rst_n,

  input  logic                                        mem_req,
  input  logic                                        mem_read,
  input  logic                                        mem_write,
  input  logic [$bits(l2_types_pkg::l2_addr_u)-1:0]   mem_addr,
  input  logic [l2_types_pkg::half_w-1:0]             mem_wdata,
  output logic                                        mem_ack,
  output logic [l2_types_pkg::half_w-1:0]             mem_rdata,

  output logic                                        pmem_req,
  output logic                                        pmem_write,
  output logic [$bits(l2_types_pkg::l2_addr_u)-1:0]   pmem_addr,
  output logic [l2_types_pkg::line_w-1:0]             pmem_wdata,
  input  logic [l2_types_pkg::line_w-1:0]             pmem_rdata,
  input  logic                                        pmem_ack
);

  logic hit;
  logic victim_dirty;
  logic data_sel_pmem;
  logic array_write;
  logic valid_in;
  logic dirty_in;
  logic addr_sel_victim;
  logic lru_write;

  l2_cache_control control (
    .clk             (clk),
    .rst_n           (rst_n),
    .mem_req         (mem_req),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .hit             (hit),
    .victim_dirty    (victim_dirty),
    .pmem_ack        (pmem_ack),
    .mem_ack         (mem_ack),
    .pmem_req        (pmem_req),
    .pmem_write      (pmem_write),
    .data_sel_pmem   (data_sel_pmem),
    .array_write     (array_write),
    .valid_in        (valid_in),
    .dirty_in        (dirty_in),
    .addr_sel_victim (addr_sel_victim),
    .lru_write       (lru_write)
  );

  l2_cache_datapath datapath (
    .clk             (clk),
    .rst_n           (rst_n),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .pmem_rdata      (pmem_rdata),
    .data_sel_pmem   (data_sel_pmem),
    .array_write     (array_write),
    .valid_in        (valid_in),
    .dirty_in        (dirty_in),
    .addr_sel_victim (addr_sel_victim),
    .lru_write       (lru_write),
    .hit             (hit),
    .victim_dirty    (victim_dirty),
    .mem_rdata       (mem_rdata),
    .pmem_wdata      (pmem_wdata),
    .pmem_addr       (pmem_addr)
  );

endmodule

// File: l2_cache_cases.txt
// op (1 read, 2 write), addr, wdata, expected rdata, check, expected write-back addr
// check: 0 none, 1 hit with no memory request, 2 miss without write-back, 3 miss with write-back
// Set 0: cold miss, repeat hit, write hit, both halves
1 1200 0 4854485648504852485c485e4858485a 2 0
1 1200 0 4854485648504852485c485e4858485a 1 0
2 1200 0123456789abcdef0011223344556677 0 1 0
1 1200 0 0123456789abcdef0011223344556677 1 0
1 1210 0 4844484648404842484c484e4848484a 1 0
// Set 1: fill four ways with dirty lines
2 3020 a0a1a2a3a4a5a6a7a8a9aaabacadaeaf 0 2 0
2 3120 b0b1b2b3b4b5b6b7b8b9babbbcbdbebf 0 2 0
2 3220 c0c1c2c3c4c5c6c7c8c9cacbcccdcecf 0 2 0
2 3320 d0d1d2d3d4d5d6d7d8d9dadbdcdddedf 0 2 0
// Touch tag 30, then tag 34 evicts tag 31
1 3020 0 a0a1a2a3a4a5a6a7a8a9aaabacadaeaf 1 0
1 3420 0 6e746e766e706e726e7c6e7e6e786e7a 3 3120
// Tag 31 comes back from memory with its written half
1 3120 0 b0b1b2b3b4b5b6b7b8b9babbbcbdbebf 3 3220
1 3130 0 6b646b666b606b626b6c6b6e6b686b6a 1 0
// Steer the tree to a clean victim
1 3320 0 d0d1d2d3d4d5d6d7d8d9dadbdcdddedf 1 0
1 3020 0 a0a1a2a3a4a5a6a7a8a9aaabacadaeaf 1 0
1 3520 0 6f746f766f706f726f7c6f7e6f786f7a 2 0
1 3420 0 6e746e766e706e726e7c6e7e6e786e7a 2 0

// File: l2_cache_control.sv
module l2_cache_control (
  input  logic clk,
  input  logic rst_n,
  input  logic mem_req,
  input  logic mem_read,
  input  logic mem_write,
  input  logic hit,
  input  logic victim_dirty,
  input  logic pmem_ack,
  output logic mem_ack,
  output logic pmem_req,
  output logic pmem_write,
  output logic data_sel_pmem,
  output logic array_write,
  output logic valid_in,
  output logic dirty_in,
  output logic addr_sel_victim,
  output logic lru_write
);
  import l2_types_pkg::*;

  l2_state_e state;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      mem_ack  <= 1'b0;
      pmem_req <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (mem_req && (mem_read || mem_write))
          begin
            if (hit)
            begin
              state <= hit_serve;
            end
            else
            begin
              state    <= victim_dirty ? writeback : allocate;
              pmem_req <= 1'b1;                     // Memory ack is already low here
            end
          end
        end
        hit_serve:
        begin
          state   <= respond;
          mem_ack <= 1'b1;
        end
        writeback:
        begin
          if (pmem_req && pmem_ack)
          begin
            pmem_req <= 1'b0;
          end
          else if (!pmem_req && !pmem_ack)
          begin
            state    <= allocate;
            pmem_req <= 1'b1;
          end
        end
        allocate:
        begin
          if (pmem_req && pmem_ack)
          begin
            pmem_req <= 1'b0;
          end
          else if (!pmem_req && !pmem_ack)
          begin
            state <= idle;                          // Lookup again, now a hit
          end
        end
        respond:
        begin
          if (!mem_req)
          begin
            state   <= idle;
            mem_ack <= 1'b0;
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  always_comb
  begin
    pmem_write      = 1'b0;
    data_sel_pmem   = 1'b0;
    array_write     = 1'b0;
    valid_in        = 1'b0;
    dirty_in        = 1'b0;
    addr_sel_victim = 1'b0;
    lru_write       = 1'b0;
    case (state)
      hit_serve:
      begin
        array_write = mem_write;                    // Read hits only touch the LRU
        valid_in    = 1'b1;
        dirty_in    = 1'b1;
        lru_write   = 1'b1;
      end
      writeback:
      begin
        pmem_write      = 1'b1;
        addr_sel_victim = 1'b1;
      end
      allocate:
      begin
        data_sel_pmem = 1'b1;
        array_write   = pmem_req && pmem_ack;       // Line is valid while ack is high
        valid_in      = 1'b1;
      end
      default:
      begin
        array_write = 1'b0;
      end
    endcase
  end

endmodule

// File: l2_cache_datapath.sv
module l2_cache_datapath (
  input  logic                             clk,
  input  logic                             rst_n,
  input  l2_types_pkg::l2_addr_u           mem_addr,
  input  logic [l2_types_pkg::half_w-1:0]  mem_wdata,
  input  logic [l2_types_pkg::line_w-1:0]  pmem_rdata,
  input  logic                             data_sel_pmem,
  input  logic                             array_write,
  input  logic                             valid_in,
  input  logic                             dirty_in,
  input  logic                             addr_sel_victim,
  input  logic                             lru_write,
  output logic                             hit,
  output logic                             victim_dirty,
  output logic [l2_types_pkg::half_w-1:0]  mem_rdata,
  output logic [l2_types_pkg::line_w-1:0]  pmem_wdata,
  output logic [l2_types_pkg::word_w-1:0]  pmem_addr
);
  import l2_types_pkg::*;

  logic [line_w-1:0] data_out [ways];
  logic [tag_w-1:0]  tag_out  [ways];
  logic [ways-1:0]   valid_out;
  logic [ways-1:0]   dirty_out;
  logic [ways-1:0]   way_match;
  logic [ways-1:0]   way_write;

  logic [1:0]        hit_way;
  logic [1:0]        victim_way;
  logic [1:0]        sel_way;
  logic [plru_w-1:0] lru_bits;
  logic [plru_w-1:0] lru_next;

  logic [line_w-1:0] hit_line;
  logic [line_w-1:0] merged_line;
  logic [line_w-1:0] line_in;
  logic              upper_half;
  l2_addr_u          wb_addr;

  generate
    for (genvar w = 0; w < ways; w++)
    begin : g_way
      l2_array #(.width(line_w)) data_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (mem_addr.fields.index),
        .write   (way_write[w]),
        .datain  (line_in),
        .dataout (data_out[w])
      );

      l2_array #(.width(tag_w)) tag_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (mem_addr.fields.index),
        .write   (way_write[w]),
        .datain  (mem_addr.fields.tag),
        .dataout (tag_out[w])
      );

      l2_array #(.width(1)) valid_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (mem_addr.fields.index),
        .write   (way_write[w]),
        .datain  (valid_in),
        .dataout (valid_out[w])
      );

      l2_array #(.width(1)) dirty_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .index   (mem_addr.fields.index),
        .write   (way_write[w]),
        .datain  (dirty_in),
        .dataout (dirty_out[w])
      );

      assign way_match[w] = valid_out[w] && (tag_out[w] == mem_addr.fields.tag);
      assign way_write[w] = array_write && (sel_way == 2'(w));
    end
  endgenerate

  l2_array #(.width(plru_w)) lru_array (
    .clk     (clk),
    .rst_n   (rst_n),
    .index   (mem_addr.fields.index),
    .write   (lru_write),
    .datain  (lru_next),
    .dataout (lru_bits)
  );

  l2_plru plru (
    .lru_bits    (lru_bits),
    .touched_way (hit_way),
    .victim_way  (victim_way),
    .lru_next    (lru_next)
  );

  assign hit = |way_match;

  always_comb
  begin
    hit_way = 2'd0;
    for (int w = 0; w < ways; w++)
    begin
      if (way_match[w])
      begin
        hit_way = 2'(w);
      end
    end
  end

  assign sel_way = hit ? hit_way : victim_way;      // Write hits stay in place

  // Half-line read and write merge
  assign upper_half = mem_addr.fields.offset[offset_w-1];
  assign hit_line   = data_out[hit_way];
  assign mem_rdata  = upper_half ? hit_line[line_w-1:half_w] : hit_line[half_w-1:0];

  always_comb
  begin
    merged_line = hit_line;
    if (upper_half)
    begin
      merged_line[line_w-1:half_w] = mem_wdata;
    end
    else
    begin
      merged_line[half_w-1:0] = mem_wdata;
    end
  end

  assign line_in = data_sel_pmem ? pmem_rdata : merged_line;

  // Victim side toward memory
  assign pmem_wdata   = data_out[victim_way];
  assign victim_dirty = valid_out[victim_way] && dirty_out[victim_way];

  always_comb
  begin
    wb_addr.fields.tag    = addr_sel_victim ? tag_out[victim_way] : mem_addr.fields.tag;
    wb_addr.fields.index  = mem_addr.fields.index;
    wb_addr.fields.offset = '0;                     // Line aligned
  end

  assign pmem_addr = wb_addr.raw;

endmodule

// File: l2_cache_tb.sv
module l2_cache_tb;
  import l2_types_pkg::*;

  localparam int case_fields = 6;                   // op addr wdata rdata check wb_addr
  localparam int max_cases   = 64;
  localparam int wait_limit  = 400;
  localparam int hold_cycles = 3;
  localparam int op_read     = 1;
  localparam int op_write    = 2;
  localparam int chk_hit     = 1;
  localparam int chk_clean   = 2;
  localparam int chk_dirty   = 3;

  logic              clk;
  logic              rst_n;
  logic              mem_req;
  logic              mem_read;
  logic              mem_write;
  logic [word_w-1:0] mem_addr;
  logic [half_w-1:0] mem_wdata;
  logic              mem_ack;
  logic [half_w-1:0] mem_rdata;
  logic              pmem_req;
  logic              pmem_write;
  logic [word_w-1:0] pmem_addr;
  logic [line_w-1:0] pmem_wdata;
  logic [line_w-1:0] pmem_rdata;
  logic              pmem_ack;

  logic [half_w-1:0] cases [case_fields*max_cases];
  int                value_errors = 0;
  int                protocol_errors = 0;
  int                timeouts = 0;
  int                wb_count = 0;
  int                alloc_count = 0;
  logic [word_w-1:0] last_wb_addr = '0;
  logic              pmem_req_q;
  logic              pmem_ack_q;
  logic              mem_ack_q;
  logic              aborted = 1'b0;

  l2_cache DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_req    (mem_req),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .pmem_req   (pmem_req),
    .pmem_write (pmem_write),
    .pmem_addr  (pmem_addr),
    .pmem_wdata (pmem_wdata),
    .pmem_rdata (pmem_rdata),
    .pmem_ack   (pmem_ack)
  );

  l2_mem_model memory (
    .clk        (clk),
    .rst_n      (rst_n),
    .pmem_req   (pmem_req),
    .pmem_write (pmem_write),
    .pmem_addr  (pmem_addr),
    .pmem_wdata (pmem_wdata),
    .pmem_rdata (pmem_rdata),
    .pmem_ack   (pmem_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory request log and handshake watch
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (pmem_req && !pmem_req_q)
      begin
        if (pmem_ack_q)                             // Ack as seen on the edge req rose
        begin
          protocol_errors++;
          $display("t=%0t new pmem request raised while pmem_ack was still high", $time);
        end
        if (pmem_write)
        begin
          wb_count     <= wb_count + 1;
          last_wb_addr <= pmem_addr;
        end
        else
        begin
          alloc_count <= alloc_count + 1;
        end
      end
      if (mem_ack_q && !mem_ack && mem_req)
      begin
        protocol_errors++;
        $display("t=%0t mem_ack dropped while mem_req was still high", $time);
      end
      if (mem_ack && !mem_ack_q && !mem_req)
      begin
        protocol_errors++;
        $display("t=%0t mem_ack raised without a pending mem_req", $time);
      end
    end
    pmem_req_q <= pmem_req;
    pmem_ack_q <= pmem_ack;
    mem_ack_q  <= mem_ack;
  end

  task automatic flag_mismatch(input string name, input logic [half_w-1:0] expected,
                               input logic [half_w-1:0] actual);
    value_errors++;
    $display("ERR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
  endtask

  task automatic run_case(input int idx);
    int                base;
    int                op;
    int                check;
    int                latency;
    int                cycles;
    int                wb_before;
    int                alloc_before;
    logic [word_w-1:0] expect_wb;
    logic [half_w-1:0] expect_rdata;
    logic [half_w-1:0] got_rdata;
    logic              got_ack;
    base = idx * case_fields;
    op = int'(cases[base][3:0]);
    check = int'(cases[base+4][3:0]);
    expect_rdata = cases[base+3];
    expect_wb = cases[base+5][word_w-1:0];
    wb_before = wb_count;
    alloc_before = alloc_count;
    @(posedge clk);
    mem_req   <= 1'b1;
    mem_read  <= (op == op_read);
    mem_write <= (op == op_write);
    mem_addr  <= cases[base+1][word_w-1:0];
    mem_wdata <= cases[base+2];
    latency = 0;
    got_ack = 1'b0;
    while (!got_ack && latency < wait_limit)
    begin
      @(posedge clk);
      latency++;
      @(negedge clk);
      got_ack = mem_ack;
    end
    if (!got_ack)
    begin
      timeouts++;
      aborted = 1'b1;
      $display("t=%0t case %0d got no mem_ack within %0d cycles", $time, idx, wait_limit);
      return;
    end
    got_rdata = mem_rdata;
    for (int h = 0; h < hold_cycles; h++)
    begin
      @(negedge clk);
      if (!mem_ack)
      begin
        protocol_errors++;
        $display("t=%0t case %0d mem_ack fell before mem_req was released", $time, idx);
      end
    end
    @(posedge clk);
    mem_req   <= 1'b0;
    mem_read  <= 1'b0;
    mem_write <= 1'b0;
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (mem_ack && cycles < wait_limit);
    if (mem_ack)
    begin
      timeouts++;
      aborted = 1'b1;
      $display("t=%0t case %0d mem_ack never released after mem_req fell", $time, idx);
      return;
    end
    if (op == op_read && got_rdata !== expect_rdata)
    begin
      flag_mismatch("mem_rdata", expect_rdata, got_rdata);
    end
    if (check == chk_hit && latency != 2)
    begin
      flag_mismatch("mem_ack latency", 2, latency);
    end
    if (check == chk_hit && (wb_count + alloc_count) != (wb_before + alloc_before))
    begin
      flag_mismatch("pmem_req count", 0, (wb_count + alloc_count) - (wb_before + alloc_before));
    end
    if ((check == chk_clean || check == chk_dirty) && alloc_count != alloc_before + 1)
    begin
      flag_mismatch("pmem_req read count", 1, alloc_count - alloc_before);
    end
    if (check == chk_clean && wb_count != wb_before)
    begin
      flag_mismatch("pmem_req write count", 0, wb_count - wb_before);
    end
    if (check == chk_dirty && wb_count != wb_before + 1)
    begin
      flag_mismatch("pmem_req write count", 1, wb_count - wb_before);
    end
    if (check == chk_dirty && last_wb_addr !== expect_wb)
    begin
      flag_mismatch("pmem_addr", expect_wb, last_wb_addr);
    end
  endtask

  initial
  begin
    int n;
    rst_n     = 1'b0;
    mem_req   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    for (int i = 0; i < case_fields * max_cases; i++)
    begin
      cases[i] = '0;                                // Op zero ends the list
    end
    $readmemh("l2_cache_cases.txt", cases);
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (mem_ack !== 1'b0 || pmem_req !== 1'b0)
    begin
      protocol_errors++;
      $display("t=%0t mem_ack or pmem_req not low after reset", $time);
    end
    n = 0;
    while (n < max_cases && cases[n*case_fields] != '0 && !aborted)
    begin
      run_case(n);
      n++;
    end
    if (n == 0)
    begin
      value_errors++;
      $display("no requests found in l2_cache_cases.txt");
    end
    $display("Checks over %0d requests: %0d value errors, %0d protocol errors, %0d timeouts",
             n, value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: l2_mem_model.sv
module l2_mem_model (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            pmem_req,
  input  logic                            pmem_write,
  input  logic [l2_types_pkg::word_w-1:0] pmem_addr,
  input  logic [l2_types_pkg::line_w-1:0] pmem_wdata,
  output logic [l2_types_pkg::line_w-1:0] pmem_rdata,
  output logic                            pmem_ack
);
  import l2_types_pkg::*;

  localparam int line_words = line_w / 16;

  logic [15:0] words [2**(word_w-1)];               // One entry per 16-bit word
  logic [31:0] lfsr;
  logic [4:0]  wait_cnt;
  logic        busy;

  // Galois LFSR, one step per delay bit taken
  function automatic logic [36:0] draw_delay(input logic [31:0] state);
    logic [31:0] s;
    logic [4:0]  bits;
    s = state;
    bits = '0;
    for (int i = 0; i < 5; i++)
    begin
      bits = {bits[3:0], s[0]};
      s = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    end
    return {s, bits};
  endfunction

  initial
  begin
    for (int i = 0; i < 2**(word_w-1); i++)
    begin
      words[i] = 16'(2 * i) ^ 16'h5a5a;             // Byte address xor pattern
    end
  end

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pmem_ack   <= 1'b0;
      pmem_rdata <= '0;
      busy       <= 1'b0;
      wait_cnt   <= '0;
      lfsr       <= 32'hbe9f;
    end
    else if (pmem_ack)
    begin
      if (!pmem_req)
      begin
        pmem_ack <= 1'b0;                           // Release after req falls
      end
    end
    else if (busy)
    begin
      if (wait_cnt != 0)
      begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      else
      begin
        busy     <= 1'b0;
        pmem_ack <= 1'b1;
        for (int k = 0; k < line_words; k++)
        begin
          if (pmem_write)
          begin
            words[{pmem_addr[word_w-1:offset_w], 4'(k)}] <= pmem_wdata[16*k +: 16];
          end
          else
          begin
            pmem_rdata[16*k +: 16] <= words[{pmem_addr[word_w-1:offset_w], 4'(k)}];
          end
        end
      end
    end
    else if (pmem_req)
    begin
      busy             <= 1'b1;
      {lfsr, wait_cnt} <= draw_delay(lfsr);
    end
  end

endmodule

// File: l2_plru.sv
module l2_plru (
  input  logic [l2_types_pkg::plru_w-1:0] lru_bits,
  input  logic [1:0]                      touched_way,
  output logic [1:0]                      victim_way,
  output logic [l2_types_pkg::plru_w-1:0] lru_next
);

  // Bit 2 is the root, bit 1 chooses within ways 0/1, bit 0 within ways 2/3
  logic root;
  logic left_pair;
  logic right_pair;

  assign root       = lru_bits[2];
  assign left_pair  = lru_bits[1];
  assign right_pair = lru_bits[0];

  always_comb
  begin
    if (root)                                       // Right pair is older
    begin
      victim_way = {1'b1, right_pair};
    end
    else
    begin
      victim_way = {1'b0, left_pair};
    end
  end

  // Point every bit on the touched path away from the touched way
  always_comb
  begin
    lru_next    = lru_bits;
    lru_next[2] = ~touched_way[1];
    if (touched_way[1])
    begin
      lru_next[0] = ~touched_way[0];
    end
    else
    begin
      lru_next[1] = ~touched_way[0];
    end
  end

endmodule

// File: l2_types_pkg.sv
package l2_types_pkg;

  // Address geometry
  localparam int word_w   = 16;
  localparam int tag_w    = 8;
  localparam int index_w  = 3;
  localparam int offset_w = 5;

  // Transfer sizes
  localparam int line_w = 256;                      // One physical memory line
  localparam int half_w = 128;                      // One L1 transfer

  // Organization
  localparam int ways   = 4;
  localparam int plru_w = 3;                        // Tree bits per set

  typedef struct packed {
    logic [tag_w-1:0]    tag;
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;                    // Top bit picks the half line
  } l2_addr_fields_s;

  // Request and write-back address, seen as a word or as its fields
  typedef union packed {
    logic [word_w-1:0] raw;
    l2_addr_fields_s   fields;
  } l2_addr_u;

  typedef enum logic [2:0] {
    idle      = 3'd0,                               // Lookup of a new request
    hit_serve = 3'd1,                               // Array write and LRU update
    writeback = 3'd2,                               // Dirty victim out to memory
    allocate  = 3'd3,                               // Missed line in from memory
    respond   = 3'd4                                // Ack held until L1 drops req
  } l2_state_e;

endpackage
